// ==== mem_map_decode.sv ====
// Unmapped CPU addresses select no slot and the CPU may only write to the RAM region
`timescale 1ns/100ps

module mem_map_decode import mem_mux_pkg::*; #(
    parameter sdram_addr_t ROM_OFFSET  = 22'h00_0000,
    parameter sdram_addr_t RAM_OFFSET  = 22'h10_0000,
    parameter sdram_addr_t VRAM_OFFSET = 22'h10_8000,
    parameter sdram_addr_t GFX_OFFSET  = 22'h20_0000
) (
    input  logic                        main_cs,
    input  cpu_addr_t                   main_addr,
    input  logic                        main_rnw,
    input  logic                        vram_cs,
    input  logic [17:0]                 vram_addr,
    input  logic                        gfx_cs,
    input  sdram_addr_t                 gfx_addr,
    output logic [NUM_SLOTS-1:0]        slot_cs,
    output sdram_addr_t [NUM_SLOTS-1:0] slot_addr,
    output logic                        slot_wr,
    output logic [SLOT_VRAM:0]          main_sel
);

    logic        rom_sel;
    logic        ram_sel;
    logic        vram_sel;
    sdram_addr_t cpu_vram_rel;
    sdram_addr_t vram_local;

    // CPU regions by byte address
    // ROM below 0x200000, RAM at 0xFF0000 and up
    assign rom_sel  = main_cs && main_addr[22:20] == 3'd0;
    assign ram_sel  = main_cs && main_addr[22:15] == 8'hFF;
    assign vram_sel = main_cs && main_addr >= CPU_VRAM_BASE && main_addr <= CPU_VRAM_LAST;

    assign main_sel = {vram_sel, ram_sel, rom_sel};

    // Word offset inside the CPU VRAM window
    assign cpu_vram_rel = sdram_addr_t'(main_addr - CPU_VRAM_BASE);

    // CPU takes the VRAM slot over the video side
    assign vram_local = vram_sel ? cpu_vram_rel : {4'd0, vram_addr};

    assign slot_cs[SLOT_ROM]  = rom_sel;
    assign slot_cs[SLOT_RAM]  = ram_sel;
    assign slot_cs[SLOT_VRAM] = vram_sel || vram_cs;
    assign slot_cs[SLOT_GFX]  = gfx_cs;

    // Additions wrap at 2^22
    assign slot_addr[SLOT_ROM]  = ROM_OFFSET  + {2'd0, main_addr[19:0]};
    assign slot_addr[SLOT_RAM]  = RAM_OFFSET  + {7'd0, main_addr[14:0]};
    assign slot_addr[SLOT_VRAM] = VRAM_OFFSET + vram_local;
    assign slot_addr[SLOT_GFX]  = GFX_OFFSET  + gfx_addr;

    assign slot_wr = ram_sel && !main_rnw;

    // Region windows must never overlap
    always_comb begin
        a_one_region: assert ($onehot0(main_sel))
            else $error("CPU address 0x%h selects more than one region", main_addr);
    end

endmodule

// ==== mem_mux_pkg.sv ====
// Slot index sets priority and every SDRAM address is a 22-bit word address
package mem_mux_pkg;

    // Data words of the 16-bit clients
    typedef logic [15:0] word16_t;

    // Graphics ROM word and SDRAM data bus
    typedef logic [31:0] word32_t;

    // SDRAM word address, 4M words of 32 bits
    typedef logic [21:0] sdram_addr_t;

    // CPU word address, byte address bits 23:1
    typedef logic [22:0] cpu_addr_t;

    // Number of clients sharing the SDRAM
    localparam int NUM_SLOTS = 4;

    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;

    // Slot numbers, lowest index wins arbitration
    localparam slot_idx_t SLOT_ROM  = 2'd0;
    localparam slot_idx_t SLOT_RAM  = 2'd1;
    localparam slot_idx_t SLOT_VRAM = 2'd2;
    localparam slot_idx_t SLOT_GFX  = 2'd3;

    // CPU view of VRAM, bytes 0x900000 to 0x92FFFF as word addresses
    localparam cpu_addr_t CPU_VRAM_BASE = 23'h48_0000;
    localparam cpu_addr_t CPU_VRAM_LAST = 23'h49_7FFF;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_slot_mux -f vlog.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== sdram_slot_arbiter.sv ====
// One SDRAM access in flight at a time and only the RAM slot writes, data in the low half
`timescale 1ns/100ps

module sdram_slot_arbiter import mem_mux_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [NUM_SLOTS-1:0]        slot_cs,
    input  logic [NUM_SLOTS-1:0]        slot_hit,
    input  sdram_addr_t [NUM_SLOTS-1:0] slot_addr,
    input  logic                        slot_wr,
    input  word16_t                     main_dout,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  word32_t                     data_read,
    output logic                        sdram_req,
    output sdram_addr_t                 sdram_addr,
    output logic                        sdram_rnw,
    output word32_t                     data_write,
    output slot_idx_t                   grant_slot,
    output logic                        done,
    output word32_t                     rd_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t               state;
    logic [NUM_SLOTS-1:0] pending;
    slot_idx_t            pick;
    logic                 launch;
    logic                 done_q;

    // A slot that already holds its data needs no access
    assign pending = slot_cs & ~slot_hit;

    // Fixed priority pick
    always_comb begin
        pick = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = slot_idx_t'(i);
            end
        end
    end

    // Skip the done cycle so the result stage can latch first
    assign launch = state == ST_IDLE && |pending && !done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            grant_slot <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        state      <= ST_REQ;
                        grant_slot <= pick;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields stay put until the next launch
    always_ff @(posedge clk) begin
        if (launch) begin
            sdram_addr <= slot_addr[pick];
            sdram_rnw  <= !(pick == SLOT_RAM && slot_wr);
            data_write <= {16'h0000, main_dout};
        end
        if (state == ST_WAIT && data_rdy) begin
            rd_data <= data_read;
        end
    end

    assign sdram_req = state == ST_REQ;

    // Result is dropped if the client left or moved to another address
    assign done = done_q && slot_cs[grant_slot] && slot_addr[grant_slot] == sdram_addr;

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr) && $stable(sdram_rnw));

    // Controller completes only an access that is waiting for its data
    a_rdy_in_wait: assert property (@(posedge clk) disable iff (rst)
        data_rdy |-> state == ST_WAIT);

endmodule

// ==== sdram_slot_mux.sv ====
// Clients hold cs, address and write data until ok, and SDRAM refresh is left to the controller
`timescale 1ns/100ps

module sdram_slot_mux import mem_mux_pkg::*; #(
    parameter sdram_addr_t ROM_OFFSET  = 22'h00_0000,
    parameter sdram_addr_t RAM_OFFSET  = 22'h10_0000,
    parameter sdram_addr_t VRAM_OFFSET = 22'h10_8000,
    parameter sdram_addr_t GFX_OFFSET  = 22'h20_0000
) (
    input  logic        clk,
    input  logic        rst,
    // CPU bus
    input  logic        main_cs,
    input  cpu_addr_t   main_addr,
    input  logic        main_rnw,
    input  word16_t     main_dout,
    output word16_t     main_data,
    output logic        main_ok,
    // Video side
    input  logic        vram_cs,
    input  logic [17:0] vram_addr,
    output word16_t     vram_data,
    output logic        vram_ok,
    input  logic        gfx_cs,
    input  sdram_addr_t gfx_addr,
    output word32_t     gfx_data,
    output logic        gfx_ok,
    // SDRAM controller
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    output logic        sdram_rnw,
    output word32_t     data_write,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  word32_t     data_read
);

    logic [NUM_SLOTS-1:0]        slot_cs;
    sdram_addr_t [NUM_SLOTS-1:0] slot_addr;
    logic                        slot_wr;
    logic [SLOT_VRAM:0]          main_sel;
    logic [NUM_SLOTS-1:0]        slot_hit;
    logic [NUM_SLOTS-1:0]        slot_ok;
    slot_idx_t                   grant_slot;
    logic                        done;
    word32_t                     rd_data;
    word16_t [SLOT_VRAM:0]       word_data;

    mem_map_decode #(
        .ROM_OFFSET     ( ROM_OFFSET    ),
        .RAM_OFFSET     ( RAM_OFFSET    ),
        .VRAM_OFFSET    ( VRAM_OFFSET   ),
        .GFX_OFFSET     ( GFX_OFFSET    )
    ) u_decode (
        .main_cs        ( main_cs       ),
        .main_addr      ( main_addr     ),
        .main_rnw       ( main_rnw      ),
        .vram_cs        ( vram_cs       ),
        .vram_addr      ( vram_addr     ),
        .gfx_cs         ( gfx_cs        ),
        .gfx_addr       ( gfx_addr      ),
        .slot_cs        ( slot_cs       ),
        .slot_addr      ( slot_addr     ),
        .slot_wr        ( slot_wr       ),
        .main_sel       ( main_sel      )
    );

    sdram_slot_arbiter u_arbiter (
        .clk            ( clk           ),
        .rst            ( rst           ),
        .slot_cs        ( slot_cs       ),
        .slot_hit       ( slot_hit      ),
        .slot_addr      ( slot_addr     ),
        .slot_wr        ( slot_wr       ),
        .main_dout      ( main_dout     ),
        .sdram_ack      ( sdram_ack     ),
        .data_rdy       ( data_rdy      ),
        .data_read      ( data_read     ),
        .sdram_req      ( sdram_req     ),
        .sdram_addr     ( sdram_addr    ),
        .sdram_rnw      ( sdram_rnw     ),
        .data_write     ( data_write    ),
        .grant_slot     ( grant_slot    ),
        .done           ( done          ),
        .rd_data        ( rd_data       )
    );

    // 16-bit slots, only the RAM slot writes
    for (genvar i = 0; i <= SLOT_VRAM; i++) begin : g_word_slot
        slot_result #(
            .data_t     ( word16_t      )
        ) u_result (
            .clk        ( clk           ),
            .rst        ( rst           ),
            .cs         ( slot_cs[i]    ),
            .addr       ( slot_addr[i]  ),
            .done_here  ( done && grant_slot == slot_idx_t'(i) ),
            .rd_data    ( rd_data       ),
            .wr_data    ( main_dout     ),
            .wr         ( i == SLOT_RAM ? slot_wr : 1'b0 ),
            .data       ( word_data[i]  ),
            .ok         ( slot_ok[i]    ),
            .hit        ( slot_hit[i]   )
        );
    end

    slot_result #(
        .data_t         ( word32_t      )
    ) u_gfx_result (
        .clk            ( clk                       ),
        .rst            ( rst                       ),
        .cs             ( slot_cs[SLOT_GFX]         ),
        .addr           ( slot_addr[SLOT_GFX]       ),
        .done_here      ( done && grant_slot == SLOT_GFX ),
        .rd_data        ( rd_data                   ),
        .wr_data        ( main_dout                 ),
        .wr             ( 1'b0                      ),
        .data           ( gfx_data                  ),
        .ok             ( slot_ok[SLOT_GFX]         ),
        .hit            ( slot_hit[SLOT_GFX]        )
    );

    // CPU data from whichever region it addressed
    always_comb begin
        main_data = '0;
        for (int i = 0; i <= SLOT_VRAM; i++) begin
            if (main_sel[i]) begin
                main_data = word_data[i];
            end
        end
    end

    assign main_ok = |(main_sel & slot_ok[SLOT_VRAM:0]);

    // VRAM slot answers the video side only when the CPU is not on it
    assign vram_data = word_data[SLOT_VRAM];
    assign vram_ok   = slot_ok[SLOT_VRAM] && !main_sel[SLOT_VRAM];
    assign gfx_ok    = slot_ok[SLOT_GFX];

endmodule

// ==== slot_result.sv ====
// Keeps the last word while cs stays high and forgets it as soon as cs falls
`timescale 1ns/100ps

module slot_result import mem_mux_pkg::*; #(
    parameter type data_t = word16_t
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  sdram_addr_t addr,
    input  logic        done_here,
    input  word32_t     rd_data,
    input  word16_t     wr_data,
    input  logic        wr,
    output data_t       data,
    output logic        ok,
    output logic        hit
);

    logic        valid;
    sdram_addr_t addr_q;
    logic        wr_q;
    data_t       data_q;
    data_t       fresh;

    // Writes keep the stored word as the slot data
    assign fresh = wr ? data_t'(wr_data) : data_t'(rd_data);

    // Same address and same direction as the last access
    assign hit = cs && valid && addr == addr_q && wr == wr_q;

    // Fresh data goes out in the done cycle itself
    assign ok   = hit || done_here;
    assign data = done_here ? fresh : data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (!cs) begin
            valid <= 1'b0;
        end else if (done_here) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (done_here) begin
            addr_q <= addr;
            wr_q   <= wr;
            data_q <= fresh;
        end
    end

    // done from the arbiter must only come for a live request
    a_ok_needs_cs: assert property (@(posedge clk) disable iff (rst)
        ok |-> cs);

    // Data holds once ok is given and the request is unchanged
    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        ok ##1 (cs && $stable(addr) && $stable(wr)) |-> ok && $stable(data));

endmodule

// ==== tb_sdram_model.sv ====
// Behavioral SDRAM controller for simulation only, one access at a time, no refresh
`timescale 1ns/100ps

module tb_sdram_model import mem_mux_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    input  logic        sdram_rnw,
    input  word32_t     data_write,
    output logic        sdram_ack,
    output logic        data_rdy,
    output word32_t     data_read,
    output int          req_count
);

    // Written words, low half only
    word16_t     store [sdram_addr_t];
    int          ack_wait;
    int          rdy_wait;
    logic [1:0]  phase;
    sdram_addr_t acc_addr;
    logic        acc_rnw;
    word16_t     acc_data;

    // Upper bits are the inverted low address bits
    function automatic word32_t read_word(input sdram_addr_t a);
        word32_t w;
        w = {~a[9:0], a};
        if (store.exists(a)) begin
            w[15:0] = store[a];
        end
        return w;
    endfunction

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        req_count = 0;
        phase     = 2'd0;
        forever begin
            @(posedge clk);
            #1;
            sdram_ack = 1'b0;
            data_rdy  = 1'b0;
            if (rst) begin
                phase = 2'd0;
            end else begin
                if (phase == 2'd0 && sdram_req) begin
                    req_count++;
                    ack_wait = $urandom_range(3, 0);
                    phase    = 2'd1;
                end else if (phase == 2'd1) begin
                    ack_wait--;
                end else if (phase == 2'd2) begin
                    rdy_wait--;
                    if (rdy_wait == 0) begin
                        data_rdy = 1'b1;
                        if (acc_rnw) begin
                            data_read = read_word(acc_addr);
                        end else begin
                            store[acc_addr] = acc_data;
                        end
                        phase = 2'd0;
                    end
                end
                // Ack may come in the first request cycle
                if (phase == 2'd1 && ack_wait == 0) begin
                    sdram_ack = 1'b1;
                    acc_addr  = sdram_addr;
                    acc_rnw   = sdram_rnw;
                    acc_data  = data_write[15:0];
                    rdy_wait  = $urandom_range(4, 1);
                    phase     = 2'd2;
                end
            end
        end
    end

endmodule

// ==== tb_sdram_slot_mux.sv ====
// Runs at the default region offsets and drives only mapped CPU addresses, reads only in pairs
`timescale 1ns/100ps

module tb_sdram_slot_mux import mem_mux_pkg::*; ();

    localparam sdram_addr_t ROM_OFFSET  = 22'h00_0000;
    localparam sdram_addr_t RAM_OFFSET  = 22'h10_0000;
    localparam sdram_addr_t VRAM_OFFSET = 22'h10_8000;
    localparam sdram_addr_t GFX_OFFSET  = 22'h20_0000;
    localparam int DRIVE_DELAY    = 1;
    localparam int HOLD_CYCLES    = 2;
    localparam int NUM_ENTRIES    = 12;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 12 + 50;

    typedef enum logic [1:0] {CL_MAIN, CL_VRAM, CL_GFX} client_t;

    // Byte address for the CPU, word address for the video clients
    typedef struct packed {
        client_t     client;
        logic [23:0] addr;
        logic        rnw;
        word16_t     wdata;
        logic        conc;
    } stim_t;

    // Client, address, rnw, write data, started together with the next entry
    localparam stim_t STIM_TABLE [NUM_ENTRIES] = '{
        '{CL_MAIN, 24'h00_1234, 1'b1, 16'h0000, 1'b0},
        '{CL_MAIN, 24'hFF_0100, 1'b0, 16'hBEEF, 1'b0},
        '{CL_MAIN, 24'hFF_0100, 1'b1, 16'h0000, 1'b0},
        '{CL_MAIN, 24'hFF_0200, 1'b1, 16'h0000, 1'b0},
        '{CL_VRAM, 24'h00_0123, 1'b1, 16'h0000, 1'b0},
        '{CL_GFX,  24'h00_1000, 1'b1, 16'h0000, 1'b0},
        '{CL_MAIN, 24'h90_0010, 1'b1, 16'h0000, 1'b0},
        '{CL_MAIN, 24'h00_0400, 1'b1, 16'h0000, 1'b1},
        '{CL_GFX,  24'h3F_FFFF, 1'b1, 16'h0000, 1'b0},
        '{CL_MAIN, 24'hFF_FFFE, 1'b0, 16'h1357, 1'b0},
        '{CL_MAIN, 24'hFF_FFFE, 1'b1, 16'h0000, 1'b0},
        '{CL_VRAM, 24'h03_FFFF, 1'b1, 16'h0000, 1'b0}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        main_cs, main_rnw, main_ok, vram_cs, vram_ok, gfx_cs, gfx_ok;
    cpu_addr_t   main_addr;
    word16_t     main_dout, main_data, vram_data;
    logic [17:0] vram_addr;
    sdram_addr_t gfx_addr, sdram_addr;
    word32_t     gfx_data, data_write, data_read;
    logic        sdram_req, sdram_rnw, sdram_ack, data_rdy;
    int          req_count;
    word16_t     shadow [sdram_addr_t];
    int          cycle_count = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    sdram_slot_mux #(
        .ROM_OFFSET(ROM_OFFSET), .RAM_OFFSET(RAM_OFFSET),
        .VRAM_OFFSET(VRAM_OFFSET), .GFX_OFFSET(GFX_OFFSET)
    ) i_dut (
        .clk(clk), .rst(rst),
        .main_cs(main_cs), .main_addr(main_addr), .main_rnw(main_rnw),
        .main_dout(main_dout), .main_data(main_data), .main_ok(main_ok),
        .vram_cs(vram_cs), .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok),
        .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_data(gfx_data), .gfx_ok(gfx_ok),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_rnw(sdram_rnw),
        .data_write(data_write), .sdram_ack(sdram_ack), .data_rdy(data_rdy),
        .data_read(data_read)
    );

    tb_sdram_model i_sdram (
        .clk(clk), .rst(rst), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .sdram_rnw(sdram_rnw), .data_write(data_write), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .req_count(req_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // SDRAM word address from the region map
    function automatic sdram_addr_t target_addr(input stim_t s);
        if (s.client == CL_VRAM) begin
            return VRAM_OFFSET + sdram_addr_t'(s.addr[17:0]);
        end
        if (s.client == CL_GFX) begin
            return GFX_OFFSET + s.addr[21:0];
        end
        if (s.addr < 24'h20_0000) begin
            return ROM_OFFSET + sdram_addr_t'(s.addr[20:1]);
        end
        if (s.addr >= 24'hFF_0000) begin
            return RAM_OFFSET + sdram_addr_t'(s.addr[15:1]);
        end
        return VRAM_OFFSET + sdram_addr_t'((s.addr - 24'h90_0000) >> 1);
    endfunction

    function automatic word32_t expected_word(input stim_t s);
        sdram_addr_t a;
        word32_t     w;
        a = target_addr(s);
        w = {~a[9:0], a};
        if (!s.rnw) begin
            w[15:0] = s.wdata;
        end else if (shadow.exists(a)) begin
            w[15:0] = shadow[a];
        end
        return w;
    endfunction

    function automatic string client_name(input client_t c);
        return c == CL_MAIN ? "main" : (c == CL_VRAM ? "vram" : "gfx");
    endfunction

    function automatic logic client_ok(input client_t c);
        return c == CL_MAIN ? main_ok : (c == CL_VRAM ? vram_ok : gfx_ok);
    endfunction

    function automatic word32_t client_data(input client_t c);
        return c == CL_MAIN ? {16'h0, main_data} : (c == CL_VRAM ? {16'h0, vram_data} : gfx_data);
    endfunction

    function automatic string describe(input stim_t s);
        return $sformatf("%s %s 0x%06h", client_name(s.client), s.rnw ? "read" : "write", s.addr);
    endfunction

    task automatic check_word16(input string name, input word16_t got, input word16_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0.1f ns %s: got 0x%04h, expected 0x%04h", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word32(input string name, input word32_t got, input word32_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0.1f ns %s: got 0x%08h, expected 0x%08h", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0.1f ns %s: got %b, expected %b", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Failure at %0.1f ns: %s", $realtime, msg);
        error_count++;
    endtask

    task automatic check_result(input stim_t s, input word32_t got, input word32_t exp);
        if (s.client == CL_GFX) begin
            check_word32("gfx_data", got, exp);
        end else begin
            check_word16({client_name(s.client), "_data"}, got[15:0], exp[15:0]);
        end
    endtask

    task automatic drive_start(input stim_t s);
        case (s.client)
            CL_MAIN: begin
                main_addr = s.addr[23:1];
                main_rnw  = s.rnw;
                main_dout = s.wdata;
                main_cs   = 1'b1;
            end
            CL_VRAM: begin
                vram_addr = s.addr[17:0];
                vram_cs   = 1'b1;
            end
            default: begin
                gfx_addr = s.addr[21:0];
                gfx_cs   = 1'b1;
            end
        endcase
    endtask

    task automatic drive_stop(input stim_t s);
        case (s.client)
            CL_MAIN: main_cs = 1'b0;
            CL_VRAM: vram_cs = 1'b0;
            default: gfx_cs = 1'b0;
        endcase
    endtask

    task automatic finish_test(input string desc, input int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, desc,
                 error_count == errs_before ? "passed" : "failed");
    endtask

    task automatic run_single(input stim_t s);
        int      errs;
        int      reqs;
        word32_t exp;
        errs = error_count;
        exp  = expected_word(s);
        drive_start(s);
        @(negedge clk);
        while (!client_ok(s.client)) begin
            @(negedge clk);
        end
        check_result(s, client_data(s.client), exp);
        if (!s.rnw) begin
            shadow[target_addr(s)] = s.wdata;
        end
        // Held request is answered from the latch
        reqs = req_count;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_bit({client_name(s.client), "_ok"}, client_ok(s.client), 1'b1);
            check_bit("sdram_req", sdram_req, 1'b0);
        end
        if (req_count != reqs) begin
            note_failure("the SDRAM saw a new request while the address was held");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        drive_stop(s);
        finish_test(describe(s), errs);
    endtask

    task automatic run_pair(input stim_t a, input stim_t b);
        int      errs;
        int      a_cycle;
        int      b_cycle;
        word32_t a_got;
        word32_t b_got;
        word32_t a_exp;
        word32_t b_exp;
        errs    = error_count;
        a_cycle = -1;
        b_cycle = -1;
        a_exp   = expected_word(a);
        b_exp   = expected_word(b);
        drive_start(a);
        drive_start(b);
        while (a_cycle < 0 || b_cycle < 0) begin
            @(negedge clk);
            if (a_cycle < 0 && client_ok(a.client)) begin
                a_cycle = cycle_count;
                a_got   = client_data(a.client);
            end
            if (b_cycle < 0 && client_ok(b.client)) begin
                b_cycle = cycle_count;
                b_got   = client_data(b.client);
            end
        end
        check_result(a, a_got, a_exp);
        check_result(b, b_got, b_exp);
        // Lower slot index wins
        if (a_cycle >= b_cycle) begin
            note_failure($sformatf("%s finished in cycle %0d, not before %s in cycle %0d",
                                   describe(a), a_cycle, describe(b), b_cycle));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        drive_stop(a);
        drive_stop(b);
        finish_test({describe(a), " with ", describe(b)}, errs);
    endtask

    initial begin
        int errs;
        int idx;
        void'($urandom(64));
        rst       = 1'b1;
        main_cs   = 1'b0;
        main_addr = '0;
        main_rnw  = 1'b1;
        main_dout = '0;
        vram_cs   = 1'b0;
        vram_addr = '0;
        gfx_cs    = 1'b0;
        gfx_addr  = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Quiet outputs before any cs
        errs = error_count;
        repeat (4) begin
            @(negedge clk);
            check_bit("main_ok", main_ok, 1'b0);
            check_bit("vram_ok", vram_ok, 1'b0);
            check_bit("gfx_ok", gfx_ok, 1'b0);
            check_bit("sdram_req", sdram_req, 1'b0);
        end
        finish_test("idle after reset", errs);
        idx = 0;
        while (idx < NUM_ENTRIES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (STIM_TABLE[idx].conc && idx + 1 < NUM_ENTRIES) begin
                run_pair(STIM_TABLE[idx], STIM_TABLE[idx + 1]);
                idx += 2;
            end else begin
                run_single(STIM_TABLE[idx]);
                idx++;
            end
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
mem_mux_pkg.sv
mem_map_decode.sv
sdram_slot_arbiter.sv
slot_result.sv
sdram_slot_mux.sv
tb_sdram_model.sv
tb_sdram_slot_mux.sv
